// File: Bender.yml
package:
  name: key_extract

export_include_dirs:
  - verilog

sources:
  - verilog/key_extract_pkg.sv
  - verilog/key_extract_if.sv
  - verilog/phv_decode.sv
  - verilog/key_table.sv
  - verilog/operand_execute.sv
  - verilog/key_assemble.sv
  - verilog/key_extract_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/key_extract_chk.sv
      - verification/key_extract_tb.sv

// File: src.f
+incdir+verilog
verilog/key_extract_pkg.sv
verilog/key_extract_if.sv
verilog/phv_decode.sv
verilog/key_table.sv
verilog/operand_execute.sv
verilog/key_assemble.sv
verilog/key_extract_top.sv
verification/tb_clock_gen.sv
verification/key_extract_chk.sv
verification/key_extract_tb.sv

// File: verification/key_extract_chk.sv
// ~~~~~~~~~~~~~~~~~~~~
// output checks, bound into key_extract_top
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "key_extract_defines.svh"

module key_extract_chk (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     phv_valid_in,
    input logic                     phv_valid_out,
    input logic                     key_valid_out,
    input logic [`KE_KEY_LEN-1:0]   key_out,
    input logic [`KE_KEY_LEN-1:0]   key_mask_out,
    input logic [`KE_PHV_LEN-1:0]   phv_out
);

    // failed assertions so far
    int err_cnt = 0;

    // three register stages from input to output
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        phv_valid_out == $past(phv_valid_in, 3))
        else begin
            err_cnt = err_cnt + 1;
            $error("phv_valid_out does not follow phv_valid_in by three cycles");
        end

    a_valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid_out == phv_valid_out)
        else begin
            err_cnt = err_cnt + 1;
            $error("key_valid_out differs from phv_valid_out");
        end

    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({phv_valid_out, key_valid_out, key_out, key_mask_out, phv_out}))
        else begin
            err_cnt = err_cnt + 1;
            $error("unknown value on an output after reset");
        end

endmodule

bind key_extract_top key_extract_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .phv_valid_in  (phv_valid_in),
    .phv_valid_out (phv_valid_out),
    .key_valid_out (key_valid_out),
    .key_out       (key_out),
    .key_mask_out  (key_mask_out),
    .phv_out       (phv_out)
);

// File: verification/key_extract_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// directed tests for the key extractor, stage KE_STAGE_ID
// all 16 table entries are written before the first PHV
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "key_extract_defines.svh"

module key_extract_tb;

    localparam int PHV_W = `KE_PHV_LEN;
    localparam int KEY_W = `KE_KEY_LEN;

    logic               clk;
    logic               rst_n;
    logic [PHV_W-1:0]   phv_in;
    logic               phv_valid_in;
    logic               wr_en;
    logic               wr_sel;
    logic [3:0]         wr_addr;
    logic [KEY_W-1:0]   wr_data;
    logic [PHV_W-1:0]   phv_out;
    logic               phv_valid_out;
    logic [KEY_W-1:0]   key_out;
    logic               key_valid_out;
    logic [KEY_W-1:0]   key_mask_out;

    // reference copies of the tables
    logic [8:0]         ref_off  [16];
    logic [KEY_W-1:0]   ref_mask [16];

    // outstanding predictions, oldest first
    logic [KEY_W-1:0]   exp_key  [$];
    logic [KEY_W-1:0]   exp_mask [$];
    logic [PHV_W-1:0]   exp_phv  [$];
    int                 exp_due  [$];
    int                 neg_cnt = 0;
    string              test_name = "none";

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    key_extract_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .wr_en         (wr_en),
        .wr_sel        (wr_sel),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [PHV_W-1:0] exp,
                               input logic [PHV_W-1:0] act);
        assert (act === exp) else
            abort_run($sformatf("** Error %s %s: expected %0h, actual %0h",
                                test_name, what, exp, act));
    endtask

    // size 2 is 6B, 1 is 4B, 0 is 2B, 3 reads as zero
    function automatic logic [47:0] cont_of(input logic [PHV_W-1:0] phv, input int size,
                                             input int idx);
        logic [47:0] val;
        val = '0;
        case (size)
            2: val = phv[PHV_W - 48*(8-idx) +: 48];
            1: val[31:0] = phv[PHV_W - 384 - 32*(8-idx) +: 32];
            0: val[15:0] = phv[PHV_W - 640 - 16*(8-idx) +: 16];
            default: val = '0;
        endcase
        return val;
    endfunction

    function automatic logic [PHV_W-1:0] set_low_byte(input logic [PHV_W-1:0] phv,
                                                      input int size, input int idx,
                                                      input logic [7:0] v);
        case (size)
            2: phv[PHV_W - 48*(8-idx) +: 8] = v;
            1: phv[PHV_W - 384 - 32*(8-idx) +: 8] = v;
            default: phv[PHV_W - 640 - 16*(8-idx) +: 8] = v;
        endcase
        return phv;
    endfunction

    function automatic logic [7:0] opd_value(input logic [PHV_W-1:0] phv,
                                             input logic [8:0] opd);
        logic [47:0] c;
        c = cont_of(phv, opd[4:3], opd[2:0]);
        return opd[8] ? opd[7:0] : c[7:0];
    endfunction

    function automatic logic [8:0] cont_ref(input logic [1:0] size, input logic [2:0] idx);
        return {1'b0, 3'b000, size, idx};
    endfunction

    // reference model of the key
    function automatic logic [KEY_W-1:0] predict_key(input logic [PHV_W-1:0] phv);
        logic [19:0] op;
        logic [8:0]  off;
        logic [7:0]  a;
        logic [7:0]  b;
        logic        hit;
        logic [47:0] c6;
        logic [47:0] c4;
        logic [47:0] c2;
        logic [4:0]  cmp;
        op  = phv[`KE_OP_TOP - `KE_OP_W*`KE_STAGE_ID -: 20];
        off = ref_off[phv[`KE_TENANT_HI:`KE_TENANT_LO]];
        a   = opd_value(phv, op[17:9]);
        b   = opd_value(phv, op[8:0]);
        case (op[19:18])
            2'd0: hit = (a > b);
            2'd1: hit = (a >= b);
            2'd2: hit = (a == b);
            default: hit = 1'b1;
        endcase
        c6  = cont_of(phv, 2, off[8:6]);
        c4  = cont_of(phv, 1, off[5:3]);
        c2  = cont_of(phv, 0, off[2:0]);
        cmp = 5'b00000;
        cmp[4-`KE_STAGE_ID] = hit;
        return {c6, c4[31:0], c2[15:0], cmp};
    endfunction

    function automatic logic [PHV_W-1:0] rand_phv(input logic [3:0] tenant,
                                                  input logic [19:0] op);
        logic [PHV_W-1:0] phv;
        phv = '0;
        for (int i = 0; i < 36; i++) begin
            phv = {phv[PHV_W-33:0], $urandom()};
        end
        phv[`KE_TENANT_HI:`KE_TENANT_LO] = tenant;
        phv[`KE_OP_TOP - `KE_OP_W*`KE_STAGE_ID -: 20] = op;
        return phv;
    endfunction

    function automatic logic [KEY_W-1:0] rand_mask();
        logic [127:0] r;
        r = {$urandom(), $urandom(), $urandom(), $urandom()};
        return r[KEY_W-1:0];
    endfunction

    task automatic write_table(input logic sel, input logic [3:0] addr,
                               input logic [KEY_W-1:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_sel  <= sel;
        wr_addr <= addr;
        wr_data <= data;
        if (sel) begin
            ref_mask[addr] = data;
        end else begin
            ref_off[addr] = data[8:0];
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // result due at the negedge after the third register edge
    task automatic send_phv(input logic [PHV_W-1:0] phv);
        @(posedge clk);
        phv_in       <= phv;
        phv_valid_in <= 1'b1;
        exp_key.push_back(predict_key(phv));
        exp_mask.push_back(ref_mask[phv[`KE_TENANT_HI:`KE_TENANT_LO]]);
        exp_phv.push_back(phv);
        exp_due.push_back(neg_cnt + 4);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        phv_valid_in <= 1'b0;
        while (exp_due.size() > 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_due.size() == 0) else
            abort_run($sformatf("outputs of %s did not arrive in time", test_name));
    endtask

    always @(negedge clk) begin
        neg_cnt = neg_cnt + 1;
        if (key_valid_out || phv_valid_out) begin
            assert (exp_due.size() > 0) else
                abort_run("output valid with no PHV outstanding");
            assert (exp_due[0] == neg_cnt && key_valid_out && phv_valid_out) else
                abort_run($sformatf("output valid at the wrong cycle in %s", test_name));
            check_value("key_out", exp_key[0], key_out);
            check_value("key_mask_out", exp_mask[0], key_mask_out);
            check_value("phv_out", exp_phv[0], phv_out);
            void'(exp_key.pop_front());
            void'(exp_mask.pop_front());
            void'(exp_phv.pop_front());
            void'(exp_due.pop_front());
        end else if (exp_due.size() > 0) begin
            assert (exp_due[0] > neg_cnt) else
                abort_run($sformatf("output valid missing in %s", test_name));
        end
    end

    always @(DUT.u_chk.err_cnt) begin
        if (DUT.u_chk.err_cnt != 0) begin
            abort_run($sformatf("a bound output assertion failed in %s", test_name));
        end
    end

    task automatic test_reset();
        test_name = "reset";
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("phv_valid_out", '0, phv_valid_out);
        check_value("key_valid_out", '0, key_valid_out);
        check_value("key_out", '0, key_out);
        check_value("key_mask_out", '0, key_mask_out);
        check_value("phv_out", '0, phv_out);
    endtask

    task automatic test_offsets();
        test_name = "offsets";
        for (int t = 0; t < 16; t++) begin
            write_table(1'b0, 4'(t), KEY_W'(t * 37 + 5));
            write_table(1'b1, 4'(t), rand_mask());
        end
        for (int t = 0; t < 16; t++) begin
            send_phv(rand_phv(4'(t), {2'd3, 18'($urandom())}));
            wait_drain();
        end
    endtask

    task automatic test_masks();
        test_name = "masks";
        for (int t = 0; t < 16; t++) begin
            write_table(1'b1, 4'(t), rand_mask());
        end
        for (int t = 15; t >= 0; t--) begin
            send_phv(rand_phv(4'(t), {2'd3, 18'($urandom())}));
            wait_drain();
        end
    endtask

    // kinds: imm/imm, 6B/imm, imm/4B, 2B/6B, reserved size/imm
    task automatic test_comparator();
        logic [PHV_W-1:0] phv;
        logic [7:0]       va;
        logic [8:0]       opa;
        logic [8:0]       opb;
        test_name = "comparator";
        for (int code = 0; code < 4; code++) begin
            for (int rel = -1; rel <= 1; rel++) begin
                va = 8'(100 + 9 * rel);
                for (int kind = 0; kind < 5; kind++) begin
                    opa = (kind == 1) ? cont_ref(2'd2, 3'd2) :
                          (kind == 3) ? cont_ref(2'd0, 3'd6) :
                          (kind == 4) ? cont_ref(2'd3, 3'd4) : {1'b1, va};
                    opb = (kind == 2) ? cont_ref(2'd1, 3'd5) :
                          (kind == 3) ? cont_ref(2'd2, 3'd1) : {1'b1, 8'd100};
                    phv = rand_phv(4'($urandom()), {2'(code), opa, opb});
                    phv = set_low_byte(phv, 2, 2, va);
                    phv = set_low_byte(phv, 0, 6, va);
                    phv = set_low_byte(phv, 1, 5, 8'd100);
                    phv = set_low_byte(phv, 2, 1, 8'd100);
                    send_phv(phv);
                    wait_drain();
                end
            end
        end
    endtask

    task automatic test_back_to_back();
        test_name = "back_to_back";
        for (int i = 0; i < 24; i++) begin
            send_phv(rand_phv(4'($urandom()), 20'($urandom())));
        end
        wait_drain();
    endtask

    task automatic test_rewrite();
        logic [PHV_W-1:0] phv;
        test_name = "rewrite";
        phv = rand_phv(4'd9, {2'd3, 18'($urandom())});
        send_phv(phv);
        wait_drain();
        write_table(1'b0, 4'd9, KEY_W'(ref_off[9] ^ 9'h1b5));
        write_table(1'b1, 4'd9, ~ref_mask[9]);
        send_phv(phv);
        send_phv(rand_phv(4'd3, {2'd3, 18'($urandom())}));
        wait_drain();
    endtask

    initial begin
        void'($urandom(35));
        phv_in       = '0;
        phv_valid_in = 1'b0;
        wr_en        = 1'b0;
        wr_sel       = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        test_reset();
        test_offsets();
        test_masks();
        test_comparator();
        test_back_to_back();
        test_rewrite();
        // let the last edge's concurrent checks settle
        @(negedge clk);
        $display("Test passed");
        $finish;
    end

    // room for about 300 PHVs at 20 cycles each
    initial begin
        #60000;
        abort_run("watchdog expired before the tests finished");
    end

endmodule

// File: verification/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// 10 ns clock, rst_n low for the first 10 rising edges
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: verilog/key_assemble.sv
// ~~~~~~~~~~~~~~~~~~~~
// result stage, key is {6B, 4B, 2B, 5 comparator bits}
// outputs hold their last value between PHVs
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "key_extract_defines.svh"

module key_assemble (
    input  logic                    clk,
    input  logic                    rst_n,
    exec_if.dst                     exec,
    input  logic [`KE_OFF_W-1:0]    offset,
    input  logic [`KE_KEY_LEN-1:0]  mask,
    output logic [`KE_PHV_LEN-1:0]  phv_out,
    output logic                    phv_valid_out,
    output logic [`KE_KEY_LEN-1:0]  key_out,
    output logic                    key_valid_out,
    output logic [`KE_KEY_LEN-1:0]  key_mask_out
);

    logic [`KE_CONT_IDX_W-1:0]  idx_6b;
    logic [`KE_CONT_IDX_W-1:0]  idx_4b;
    logic [`KE_CONT_IDX_W-1:0]  idx_2b;
    logic [4:0]                 cmp_field;
    logic [`KE_KEY_LEN-1:0]     key_next;

    assign idx_6b = offset[`KE_OFF_W-1 -: `KE_CONT_IDX_W];
    assign idx_4b = offset[`KE_OFF_W-1-`KE_CONT_IDX_W -: `KE_CONT_IDX_W];
    assign idx_2b = offset[`KE_CONT_IDX_W-1:0];

    // only this stage's comparator bit is set
    always_comb begin
        cmp_field = '0;
        cmp_field[4-`KE_STAGE_ID] = exec.cmp_bit;
    end

    assign key_next = {exec.cont_6b[idx_6b], exec.cont_4b[idx_4b],
                       exec.cont_2b[idx_2b], cmp_field};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_valid_out <= 1'b0;
            key_valid_out <= 1'b0;
            phv_out       <= '0;
            key_out       <= '0;
            key_mask_out  <= '0;
        end else begin
            phv_valid_out <= exec.valid;
            key_valid_out <= exec.valid;
            if (exec.valid) begin
                phv_out      <= exec.phv;
                key_out      <= key_next;
                key_mask_out <= mask;
            end
        end
    end

endmodule

// File: verilog/key_extract_defines.svh
// ~~~~~~~~~~~~~~~~~~~~
// widths and PHV field positions of the key extractor
// containers sit from the PHV top downward, 6B then 4B then 2B
// ~~~~~~~~~~~~~~~~~~~~
`ifndef KEY_EXTRACT_DEFINES_SVH
`define KEY_EXTRACT_DEFINES_SVH

`define KE_PHV_LEN     1124
`define KE_KEY_LEN     101

// container widths and count per size
`define KE_W6B         48
`define KE_W4B         32
`define KE_W2B         16
`define KE_NUM_CONT    8
`define KE_CONT_IDX_W  3

// offset entry: 6B index on top, then 4B, then 2B
`define KE_OFF_W       9

`define KE_NUM_OPS     5
`define KE_OP_W        20
`define KE_OP_TOP      355

// vlan id bits 7 to 4 in the metadata
`define KE_TENANT_HI   136
`define KE_TENANT_LO   133
`define KE_TBL_AW      4

`define KE_STAGE_ID    0

`endif

// File: verilog/key_extract_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// pipeline buses between the extractor stages
// no handshake, a valid strobe marks each PHV
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "key_extract_defines.svh"

// decoded PHV, one cycle after the input edge
interface phv_fields_if;
    logic                                           valid;
    logic [`KE_PHV_LEN-1:0]                         phv;
    logic [`KE_NUM_CONT-1:0][`KE_W6B-1:0]           cont_6b;
    logic [`KE_NUM_CONT-1:0][`KE_W4B-1:0]           cont_4b;
    logic [`KE_NUM_CONT-1:0][`KE_W2B-1:0]           cont_2b;
    logic [`KE_OP_W-1:0]                            op;
    logic [`KE_TBL_AW-1:0]                          tenant;

    modport src (output valid, phv, cont_6b, cont_4b, cont_2b, op, tenant);
    modport dst (input  valid, phv, cont_6b, cont_4b, cont_2b, op, tenant);
endinterface

// executed stage, comparator result attached
interface exec_if;
    logic                                           valid;
    logic [`KE_PHV_LEN-1:0]                         phv;
    logic [`KE_NUM_CONT-1:0][`KE_W6B-1:0]           cont_6b;
    logic [`KE_NUM_CONT-1:0][`KE_W4B-1:0]           cont_4b;
    logic [`KE_NUM_CONT-1:0][`KE_W2B-1:0]           cont_2b;
    logic                                           cmp_bit;

    modport src (output valid, phv, cont_6b, cont_4b, cont_2b, cmp_bit);
    modport dst (input  valid, phv, cont_6b, cont_4b, cont_2b, cmp_bit);
endinterface

// File: verilog/key_extract_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// comparator operand layout and op codes
// size code 3 is reserved and resolves to zero
// ~~~~~~~~~~~~~~~~~~~~
package key_extract_pkg;

    // immediate view of a comparator operand
    typedef struct packed {
        logic       is_imm;
        logic [7:0] value;
    } imm_view_t;

    // container reference view of the same word
    typedef struct packed {
        logic       is_imm;
        logic [2:0] unused;
        logic [1:0] size;
        logic [2:0] idx;
    } cont_view_t;

    typedef union packed {
        imm_view_t  imm;
        cont_view_t cont;
    } operand_u;

    localparam logic [1:0] SZ_2B = 2'd0;
    localparam logic [1:0] SZ_4B = 2'd1;
    localparam logic [1:0] SZ_6B = 2'd2;

    // comparator codes, op bits 19 to 18
    localparam logic [1:0] CMP_GT     = 2'd0;
    localparam logic [1:0] CMP_GE     = 2'd1;
    localparam logic [1:0] CMP_EQ     = 2'd2;
    localparam logic [1:0] CMP_ALWAYS = 2'd3;

endpackage

// File: verilog/key_extract_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// key extractor, 3-cycle latency, one PHV per cycle
// no back-pressure, tables written through wr_* before use
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "key_extract_defines.svh"

module key_extract_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`KE_PHV_LEN-1:0]  phv_in,
    input  logic                    phv_valid_in,
    input  logic                    wr_en,
    input  logic                    wr_sel,
    input  logic [`KE_TBL_AW-1:0]   wr_addr,
    input  logic [`KE_KEY_LEN-1:0]  wr_data,
    output logic [`KE_PHV_LEN-1:0]  phv_out,
    output logic                    phv_valid_out,
    output logic [`KE_KEY_LEN-1:0]  key_out,
    output logic                    key_valid_out,
    output logic [`KE_KEY_LEN-1:0]  key_mask_out
);

    logic [`KE_OFF_W-1:0]   tbl_offset;
    logic [`KE_KEY_LEN-1:0] tbl_mask;

    phv_fields_if fields_bus ();
    exec_if       exec_bus ();

    phv_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_in       (phv_in),
        .phv_valid_in (phv_valid_in),
        .fields       (fields_bus.src)
    );

    key_table u_table (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .fields  (fields_bus.dst),
        .offset  (tbl_offset),
        .mask    (tbl_mask)
    );

    operand_execute u_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .fields (fields_bus.dst),
        .exec   (exec_bus.src)
    );

    key_assemble u_assemble (
        .clk           (clk),
        .rst_n         (rst_n),
        .exec          (exec_bus.dst),
        .offset        (tbl_offset),
        .mask          (tbl_mask),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

endmodule

// File: verilog/key_table.sv
// ~~~~~~~~~~~~~~~~~~~~
// per-tenant offset and mask tables, 16 entries each
// contents are undefined until written
// a same-cycle read of a written entry returns old data
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "key_extract_defines.svh"

module key_table (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic                    wr_sel,
    input  logic [`KE_TBL_AW-1:0]   wr_addr,
    input  logic [`KE_KEY_LEN-1:0]  wr_data,
    phv_fields_if.dst               fields,
    output logic [`KE_OFF_W-1:0]    offset,
    output logic [`KE_KEY_LEN-1:0]  mask
);

    localparam int DEPTH = 1 << `KE_TBL_AW;

    logic [`KE_OFF_W-1:0]   off_mem  [DEPTH];
    logic [`KE_KEY_LEN-1:0] mask_mem [DEPTH];

    // wr_sel 0 picks the offset table, 1 the mask table
    always_ff @(posedge clk) begin
        if (wr_en && !wr_sel) begin
            off_mem[wr_addr] <= wr_data[`KE_OFF_W-1:0];
        end
        if (wr_en && wr_sel) begin
            mask_mem[wr_addr] <= wr_data;
        end
    end

    // read every cycle, lines up with the execute stage
    always_ff @(posedge clk) begin
        offset <= off_mem[fields.tenant];
        mask   <= mask_mem[fields.tenant];
    end

endmodule

// File: verilog/operand_execute.sv
// ~~~~~~~~~~~~~~~~~~~~
// execute stage, compares two 8-bit operands
// a container operand uses only its low byte
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "key_extract_defines.svh"

module operand_execute (
    input  logic        clk,
    input  logic        rst_n,
    phv_fields_if.dst   fields,
    exec_if.src         exec
);

    key_extract_pkg::operand_u  opd_a;
    key_extract_pkg::operand_u  opd_b;
    logic [7:0]                 val_a;
    logic [7:0]                 val_b;
    logic                       cmp_res;

    function automatic logic [7:0] resolve(
        input key_extract_pkg::operand_u                opd,
        input logic [`KE_NUM_CONT-1:0][`KE_W6B-1:0]     c6,
        input logic [`KE_NUM_CONT-1:0][`KE_W4B-1:0]     c4,
        input logic [`KE_NUM_CONT-1:0][`KE_W2B-1:0]     c2
    );
        logic [7:0] val;
        val = 8'h00;
        if (opd.imm.is_imm) begin
            val = opd.imm.value;
        end else begin
            case (opd.cont.size)
                key_extract_pkg::SZ_6B: val = c6[opd.cont.idx][7:0];
                key_extract_pkg::SZ_4B: val = c4[opd.cont.idx][7:0];
                key_extract_pkg::SZ_2B: val = c2[opd.cont.idx][7:0];
                default:                val = 8'h00;
            endcase
        end
        return val;
    endfunction

    assign opd_a = fields.op[17:9];
    assign opd_b = fields.op[8:0];
    assign val_a = resolve(opd_a, fields.cont_6b, fields.cont_4b, fields.cont_2b);
    assign val_b = resolve(opd_b, fields.cont_6b, fields.cont_4b, fields.cont_2b);

    always_comb begin
        case (fields.op[19:18])
            key_extract_pkg::CMP_GT: cmp_res = (val_a > val_b);
            key_extract_pkg::CMP_GE: cmp_res = (val_a >= val_b);
            key_extract_pkg::CMP_EQ: cmp_res = (val_a == val_b);
            default:                 cmp_res = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exec.valid <= 1'b0;
        end else begin
            exec.valid <= fields.valid;
        end
    end

    always_ff @(posedge clk) begin
        exec.phv     <= fields.phv;
        exec.cont_6b <= fields.cont_6b;
        exec.cont_4b <= fields.cont_4b;
        exec.cont_2b <= fields.cont_2b;
        exec.cmp_bit <= cmp_res;
    end

endmodule

// File: verilog/phv_decode.sv
// ~~~~~~~~~~~~~~~~~~~~
// first stage, PHV is captured only on a valid strobe
// containers, op and tenant are slices of the held PHV
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "key_extract_defines.svh"

module phv_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`KE_PHV_LEN-1:0]  phv_in,
    input  logic                    phv_valid_in,
    phv_fields_if.src               fields
);

    localparam int REGION_6B = `KE_NUM_CONT * `KE_W6B;
    localparam int REGION_4B = `KE_NUM_CONT * `KE_W4B;
    localparam int REGION_2B = `KE_NUM_CONT * `KE_W2B;

    logic                                   valid_q;
    logic [`KE_PHV_LEN-1:0]                 phv_q;
    logic [`KE_NUM_OPS-1:0][`KE_OP_W-1:0]   ops;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= phv_valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (phv_valid_in) begin
            phv_q <= phv_in;
        end
    end

    // index 7 of each size sits at the top of its region
    assign fields.cont_6b = phv_q[`KE_PHV_LEN-1 -: REGION_6B];
    assign fields.cont_4b = phv_q[`KE_PHV_LEN-1-REGION_6B -: REGION_4B];
    assign fields.cont_2b = phv_q[`KE_PHV_LEN-1-REGION_6B-REGION_4B -: REGION_2B];

    // op 0 is the highest op word
    assign ops          = phv_q[`KE_OP_TOP -: `KE_NUM_OPS*`KE_OP_W];
    assign fields.op    = ops[`KE_NUM_OPS-1-`KE_STAGE_ID];

    assign fields.tenant = phv_q[`KE_TENANT_HI:`KE_TENANT_LO];
    assign fields.phv    = phv_q;
    assign fields.valid  = valid_q;

endmodule
